/* event_queue_top.f */
source/queue_cfg_pkg.sv
source/queue_reg_pkg.sv
source/entry_fifo.sv
source/channel_steer.sv
source/drain_arbiter.sv
source/queue_apb_regs.sv
source/event_queue_top.sv
test/event_queue_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the event queue testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
    -f event_queue_top.f --top-module event_queue_tb -o sim_event_queue; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_event_queue > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

/* source/channel_steer.sv */
// Channel steering that routes each record to its FIFO and flags records to drop
`timescale 1ns/10ps

module channel_steer #(
  parameter int NUM_CHAN = 4
) (
  input  logic                        ctrl_clk,
  input  logic                        rst_b,
  input  logic                        in_valid,
  input  logic [$clog2(NUM_CHAN)-1:0] in_chan,
  input  queue_cfg_pkg::data_t        in_data,
  output logic                        in_ready,
  input  logic [NUM_CHAN-1:0]         chan_en,
  input  logic [NUM_CHAN-1:0]         chan_full,
  output logic [NUM_CHAN-1:0]         create_en,
  output queue_cfg_pkg::data_t        create_data,
  output logic                        drop_pulse
);

  logic [NUM_CHAN-1:0] chan_sel;
  logic                sel_en;
  logic                sel_full;

  // Channel numbers past NUM_CHAN decode to no channel and are dropped
  assign chan_sel = NUM_CHAN'(1) << in_chan;
  assign sel_en   = |(chan_sel & chan_en);
  assign sel_full = |(chan_sel & chan_full);

  // Only an enabled full channel stalls the producer
  assign in_ready = !(sel_en && sel_full);

  assign create_en   = {NUM_CHAN{in_valid && sel_en && !sel_full}} & chan_sel;
  assign create_data = in_data;

  // Disabled channel, record is taken and thrown away
  assign drop_pulse = in_valid && !sel_en;

  a_create_onehot: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    $onehot0(create_en));

endmodule

/* source/drain_arbiter.sv */
// Round-robin drain arbiter that moves records from the channel FIFOs to the output
`timescale 1ns/10ps

module drain_arbiter #(
  parameter int NUM_CHAN = 4
) (
  input  logic                        ctrl_clk,
  input  logic                        rst_b,
  input  logic [NUM_CHAN-1:0]         chan_vld,
  input  queue_cfg_pkg::data_t        chan_data [NUM_CHAN],
  output logic [NUM_CHAN-1:0]         pop_en,
  output logic                        out_valid,
  output logic [$clog2(NUM_CHAN)-1:0] out_chan,
  output queue_cfg_pkg::data_t        out_data,
  input  logic                        out_ready
);

  localparam int CHAN_W = $clog2(NUM_CHAN);

  logic [CHAN_W-1:0] prio_ptr;
  logic [CHAN_W-1:0] gnt_idx;
  logic              gnt_found;
  logic              xfer;

  // First non-empty channel at or after the priority pointer
  always_comb
  begin
    int cand;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      cand = (int'(prio_ptr) + i) % NUM_CHAN;
      if (!gnt_found && chan_vld[cand])
      begin
        gnt_found = 1'b1;
        gnt_idx   = CHAN_W'(cand);
      end
    end
  end

  assign xfer      = gnt_found && out_ready;
  assign out_valid = gnt_found;
  assign out_chan  = gnt_idx;
  assign out_data  = chan_data[gnt_idx];
  assign pop_en    = {NUM_CHAN{xfer}} & (NUM_CHAN'(1) << gnt_idx);

  always_ff @(posedge ctrl_clk or negedge rst_b)
  begin
    if (!rst_b)
      prio_ptr <= '0;
    else if (xfer)
      prio_ptr <= (gnt_idx == CHAN_W'(NUM_CHAN - 1)) ? '0 : gnt_idx + 1'b1;
    // Stalled, park on the granted channel so a new arrival ahead of it cannot take over
    else if (gnt_found)
      prio_ptr <= gnt_idx;
  end

  a_pop_onehot: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    $onehot0(pop_en));

  // Consumer stall keeps the offered record unchanged
  a_out_hold: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    out_valid && !out_ready |=> out_valid && $stable(out_chan) && $stable(out_data));

endmodule

/* source/entry_fifo.sv */
// Entry FIFO for one queue channel with one-hot create and binary pop pointers
`timescale 1ns/10ps

module entry_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                 ctrl_clk,
  input  logic                 rst_b,
  input  logic                 create_en,
  input  queue_cfg_pkg::data_t create_data,
  input  logic                 pop_en,
  output queue_cfg_pkg::data_t pop_data,
  output logic                 pop_data_vld,
  output logic                 full,
  output logic                 empty
);

  import queue_cfg_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [DEPTH-1:0] create_ptr;
  logic [PTR_W-1:0] pop_ptr;
  logic [DEPTH-1:0] pop_sel;
  logic [DEPTH-1:0] entry_create;
  logic [DEPTH-1:0] entry_pop;
  logic [DEPTH-1:0] entry_vld;
  data_t            entry_data [DEPTH];

  // Write slot rotates one place per create
  always_ff @(posedge ctrl_clk or negedge rst_b)
  begin
    if (!rst_b)
      create_ptr <= DEPTH'(1);
    else if (create_en)
      create_ptr <= {create_ptr[DEPTH-2:0], create_ptr[DEPTH-1]};
  end

  // Read slot counts up and wraps at the last entry
  always_ff @(posedge ctrl_clk or negedge rst_b)
  begin
    if (!rst_b)
      pop_ptr <= '0;
    else if (pop_en)
    begin
      if (pop_ptr == PTR_W'(DEPTH - 1))
        pop_ptr <= '0;
      else
        pop_ptr <= pop_ptr + 1'b1;
    end
  end

  assign pop_sel      = DEPTH'(1) << pop_ptr;
  assign entry_create = {DEPTH{create_en}} & create_ptr;
  assign entry_pop    = {DEPTH{pop_en}} & pop_sel;

  // Create and pop never hit the same entry in one cycle
  always_ff @(posedge ctrl_clk or negedge rst_b)
  begin
    if (!rst_b)
      entry_vld <= '0;
    else
      entry_vld <= (entry_vld | entry_create) & ~entry_pop;
  end

  always_ff @(posedge ctrl_clk)
  begin
    for (int i = 0; i < DEPTH; i++)
    begin
      if (entry_create[i])
        entry_data[i] <= create_data;
    end
  end

  assign full         = &entry_vld;
  assign pop_data_vld = |entry_vld;
  assign empty        = ~pop_data_vld;
  assign pop_data     = entry_data[pop_ptr];

  // Steering holds off a full channel and the arbiter only pops a valid one
  a_no_create_full: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    !(create_en && full));
  a_no_pop_empty: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    !(pop_en && empty));

endmodule

/* source/event_queue_top.sv */
// Multi-channel event queue top with steering, channel FIFOs, drain arbiter and APB registers
`timescale 1ns/10ps

module event_queue_top #(
  parameter int NUM_CHAN = queue_cfg_pkg::NUM_CHAN_DEF,
  parameter int DEPTH    = queue_cfg_pkg::DEPTH_DEF
) (
  input  logic                             ctrl_clk,
  input  logic                             rst_b,
  // Record input
  input  logic                             in_valid,
  input  logic [$clog2(NUM_CHAN)-1:0]      in_chan,
  input  queue_cfg_pkg::data_t             in_data,
  output logic                             in_ready,
  // Record output
  output logic                             out_valid,
  output logic [$clog2(NUM_CHAN)-1:0]      out_chan,
  output queue_cfg_pkg::data_t             out_data,
  input  logic                             out_ready,
  // APB register port
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [queue_reg_pkg::ADDR_W-1:0] paddr,
  input  queue_reg_pkg::reg_t              pwdata,
  output queue_reg_pkg::reg_t              prdata,
  output logic                             pready,
  output logic                             pslverr
);

  import queue_cfg_pkg::*;

  logic [NUM_CHAN-1:0] chan_en;
  logic [NUM_CHAN-1:0] chan_full;
  logic [NUM_CHAN-1:0] chan_empty;
  logic [NUM_CHAN-1:0] chan_vld;
  logic [NUM_CHAN-1:0] create_en;
  logic [NUM_CHAN-1:0] pop_en;
  logic                drop_pulse;
  data_t               create_data;
  data_t               pop_data [NUM_CHAN];

  channel_steer #(.NUM_CHAN(NUM_CHAN)) u_channel_steer (
    .ctrl_clk    (ctrl_clk),
    .rst_b       (rst_b),
    .in_valid    (in_valid),
    .in_chan     (in_chan),
    .in_data     (in_data),
    .in_ready    (in_ready),
    .chan_en     (chan_en),
    .chan_full   (chan_full),
    .create_en   (create_en),
    .create_data (create_data),
    .drop_pulse  (drop_pulse)
  );

  for (genvar c = 0; c < NUM_CHAN; c++)
  begin : g_chan
    entry_fifo #(.DEPTH(DEPTH)) u_entry_fifo (
      .ctrl_clk     (ctrl_clk),
      .rst_b        (rst_b),
      .create_en    (create_en[c]),
      .create_data  (create_data),
      .pop_en       (pop_en[c]),
      .pop_data     (pop_data[c]),
      .pop_data_vld (chan_vld[c]),
      .full         (chan_full[c]),
      .empty        (chan_empty[c])
    );
  end

  drain_arbiter #(.NUM_CHAN(NUM_CHAN)) u_drain_arbiter (
    .ctrl_clk  (ctrl_clk),
    .rst_b     (rst_b),
    .chan_vld  (chan_vld),
    .chan_data (pop_data),
    .pop_en    (pop_en),
    .out_valid (out_valid),
    .out_chan  (out_chan),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  queue_apb_regs #(.NUM_CHAN(NUM_CHAN)) u_queue_apb_regs (
    .ctrl_clk   (ctrl_clk),
    .rst_b      (rst_b),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .chan_en    (chan_en),
    .chan_full  (chan_full),
    .chan_empty (chan_empty),
    .drop_pulse (drop_pulse)
  );

endmodule

/* source/queue_apb_regs.sv */
// APB register block with channel enables, FIFO status and the dropped-record counter
`timescale 1ns/10ps

module queue_apb_regs #(
  parameter int NUM_CHAN = 4
) (
  input  logic                             ctrl_clk,
  input  logic                             rst_b,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [queue_reg_pkg::ADDR_W-1:0] paddr,
  input  queue_reg_pkg::reg_t              pwdata,
  output queue_reg_pkg::reg_t              prdata,
  output logic                             pready,
  output logic                             pslverr,
  output logic [NUM_CHAN-1:0]              chan_en,
  input  logic [NUM_CHAN-1:0]              chan_full,
  input  logic [NUM_CHAN-1:0]              chan_empty,
  input  logic                             drop_pulse
);

  import queue_reg_pkg::*;

  logic access;
  logic wr_en;
  logic hit_ctrl;
  logic hit_status;
  logic hit_drop;
  reg_t drop_cnt;
  reg_t status_word;

  assign access     = psel && penable;
  assign wr_en      = access && pwrite;
  assign hit_ctrl   = (paddr == ADDR_CTRL);
  assign hit_status = (paddr == ADDR_STATUS);
  assign hit_drop   = (paddr == ADDR_DROP);

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !(hit_ctrl || hit_status || hit_drop);

  assign status_word = (reg_t'(chan_full) << STATUS_FULL_LSB) | reg_t'(chan_empty);

  always_ff @(posedge ctrl_clk or negedge rst_b)
  begin
    if (!rst_b)
      chan_en <= '1;
    else if (wr_en && hit_ctrl)
      chan_en <= pwdata[NUM_CHAN-1:0];
  end

  // Clear wins over a drop in the same cycle, count sticks at all ones
  always_ff @(posedge ctrl_clk or negedge rst_b)
  begin
    if (!rst_b)
      drop_cnt <= '0;
    else if (wr_en && hit_drop)
      drop_cnt <= '0;
    else if (drop_pulse && !(&drop_cnt))
      drop_cnt <= drop_cnt + reg_t'(1);
  end

  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      if (hit_ctrl)
        prdata = reg_t'(chan_en);
      else if (hit_status)
        prdata = status_word;
      else if (hit_drop)
        prdata = drop_cnt;
    end
  end

  // Two-phase protocol from the bus master
  a_penable_psel: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    penable |-> psel);
  a_setup_access: assert property (@(posedge ctrl_clk) disable iff (!rst_b)
    psel && !penable |=> psel && penable);

endmodule

/* source/queue_cfg_pkg.sv */
// Queue data-path package with channel and depth defaults and the record data word

package queue_cfg_pkg;

  // Default channel count, the top level passes it down as NUM_CHAN
  parameter int NUM_CHAN_DEF = 4;

  // Default entries per channel FIFO
  parameter int DEPTH_DEF = 4;

  // Record payload width
  parameter int DATA_W = 16;

  // Data word carried by every record, from producer through FIFO to consumer
  typedef logic [DATA_W-1:0] data_t;

endpackage

/* source/queue_reg_pkg.sv */
// Register package with the APB widths, register offsets and status field layout

package queue_reg_pkg;

  // APB bus widths
  parameter int REG_W  = 32;
  parameter int ADDR_W = 8;

  // One register word
  typedef logic [REG_W-1:0] reg_t;

  // Register offsets
  parameter logic [ADDR_W-1:0] ADDR_CTRL   = 8'h00;
  parameter logic [ADDR_W-1:0] ADDR_STATUS = 8'h04;
  parameter logic [ADDR_W-1:0] ADDR_DROP   = 8'h08;

  // STATUS layout, empty mask from bit 0 and full mask from this bit
  parameter int STATUS_FULL_LSB = 8;

endpackage

/* test/event_queue_tb.sv */
// Event queue testbench with random records, a per-channel reference model and APB checks
`timescale 1ns/10ps

module event_queue_tb;

  import queue_cfg_pkg::*;
  import queue_reg_pkg::*;

  localparam int NUM_CHAN   = NUM_CHAN_DEF;
  localparam int DEPTH      = DEPTH_DEF;
  localparam int CHAN_W     = $clog2(NUM_CHAN);
  localparam int NUM_TESTS  = 6;
  localparam int CLK_PERIOD = 8;

  logic              ctrl_clk;
  logic              rst_b;
  logic              in_valid;
  logic [CHAN_W-1:0] in_chan;
  data_t             in_data;
  logic              in_ready;
  logic              out_valid;
  logic [CHAN_W-1:0] out_chan;
  data_t             out_data;
  logic              out_ready;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  reg_t              pwdata;
  reg_t              prdata;
  logic              pready;
  logic              pslverr;

  // Reference model
  data_t               model_q [NUM_CHAN][$];
  logic [NUM_CHAN-1:0] model_en;
  reg_t                model_drop;

  int                  seed = 25;
  int                  err_cnt;
  int                  test_err_base;
  int                  pass_cnt;
  int                  fail_cnt;
  int                  last_chan;
  bit                  rr_check;
  logic [CHAN_W-1:0]   chan_a;
  logic [NUM_CHAN-1:0] mask;
  reg_t                rd;
  logic                err;

  event_queue_top #(.NUM_CHAN(NUM_CHAN), .DEPTH(DEPTH)) u_event_queue_top (
    .ctrl_clk  (ctrl_clk),
    .rst_b     (rst_b),
    .in_valid  (in_valid),
    .in_chan   (in_chan),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_chan  (out_chan),
    .out_data  (out_data),
    .out_ready (out_ready),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  always #(CLK_PERIOD / 2) ctrl_clk = ~ctrl_clk;

  task automatic check_data(input data_t got, input data_t exp, input string msg);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_chan(input logic [CHAN_W-1:0] got, input logic [CHAN_W-1:0] exp,
                            input string msg);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s, got channel %0d expected %0d", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input reg_t got, input reg_t exp, input string msg);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic [CHAN_W-1:0] rand_chan();
    return CHAN_W'($unsigned($random(seed)) % NUM_CHAN);
  endfunction

  function automatic logic [CHAN_W-1:0] next_chan(input logic [CHAN_W-1:0] c);
    return CHAN_W'((int'(c) + 1) % NUM_CHAN);
  endfunction

  function automatic int model_count();
    int n;
    n = 0;
    for (int c = 0; c < NUM_CHAN; c++)
      n += model_q[c].size();
    return n;
  endfunction

  // Empty bits from 0, full bits from STATUS_FULL_LSB
  function automatic reg_t model_status();
    reg_t s;
    s = '0;
    for (int c = 0; c < NUM_CHAN; c++)
    begin
      if (model_q[c].size() == 0)
        s[c] = 1'b1;
      if (model_q[c].size() == DEPTH)
        s[STATUS_FULL_LSB + c] = 1'b1;
    end
    return s;
  endfunction

  // All stimulus tasks start and end 1 ns after a rising edge
  task automatic send_record(input logic [CHAN_W-1:0] chan, input data_t data);
    in_valid = 1'b1;
    in_chan  = chan;
    in_data  = data;
    @(negedge ctrl_clk);
    while (!in_ready)
      @(negedge ctrl_clk);
    if (model_en[chan])
      model_q[chan].push_back(data);
    else
      model_drop++;
    @(posedge ctrl_clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic probe_ready(input logic [CHAN_W-1:0] chan, input logic exp, input string msg);
    in_valid = 1'b0;
    in_chan  = chan;
    @(negedge ctrl_clk);
    check_flag(in_ready, exp, msg);
    @(posedge ctrl_clk);
    #1;
  endtask

  task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr, input reg_t wdata,
                            output reg_t rdata, output logic slverr);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge ctrl_clk);
    #1;
    penable = 1'b1;
    @(negedge ctrl_clk);
    rdata  = prdata;
    slverr = pslverr;
    check_flag(pready, 1'b1, "pready in access phase");
    @(posedge ctrl_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_drain();
    while (model_count() != 0)
    begin
      @(posedge ctrl_clk);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base)
    begin
      pass_cnt++;
      $display("Test %s: ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("Test %s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // Output monitor, compares each transfer with the front of its channel queue
  always @(negedge ctrl_clk)
  begin
    if (rst_b && out_valid && out_ready)
    begin
      if (rr_check && last_chan >= 0)
        check_chan(out_chan, next_chan(CHAN_W'(last_chan)), "round-robin order");
      last_chan = int'(out_chan);
      if (model_q[out_chan].size() == 0)
      begin
        $display("Error at %0t ns: record on channel %0d with nothing queued", $time, out_chan);
        err_cnt++;
      end
      else
        check_data(out_data, model_q[out_chan].pop_front(), "output data");
    end
  end

  initial
  begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("Watchdog expired, the run timed out before all tests finished");
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    ctrl_clk   = 1'b0;
    rst_b      = 1'b0;
    in_valid   = 1'b0;
    in_chan    = '0;
    in_data    = '0;
    out_ready  = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    model_en   = '1;
    model_drop = '0;
    last_chan  = -1;
    rr_check   = 1'b0;
    repeat (16) @(posedge ctrl_clk);
    #1;
    rst_b = 1'b1;

    check_flag(out_valid, 1'b0, "out_valid after reset");
    apb_access(1'b0, ADDR_CTRL, '0, rd, err);
    check_reg(rd, reg_t'({NUM_CHAN{1'b1}}), "CTRL after reset");
    check_flag(err, 1'b0, "pslverr on CTRL read");
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_reg(rd, model_status(), "STATUS after reset");
    end_test("reset state");

    for (int i = 0; i < 200; i++)
      send_record(rand_chan(), data_t'($random(seed)));
    wait_drain();
    end_test("per-channel order");

    out_ready = 1'b0;
    chan_a = rand_chan();
    for (int i = 0; i < DEPTH; i++)
    begin
      probe_ready(chan_a, 1'b1, "in_ready before channel full");
      send_record(chan_a, data_t'($random(seed)));
    end
    probe_ready(chan_a, 1'b0, "in_ready with channel full");
    // Other channels keep accepting
    send_record(next_chan(chan_a), data_t'($random(seed)));
    out_ready = 1'b1;
    wait_drain();
    end_test("back-pressure");

    out_ready = 1'b0;
    for (int c = 0; c < NUM_CHAN; c++)
      for (int i = 0; i < DEPTH; i++)
        send_record(CHAN_W'(c), data_t'($random(seed)));
    last_chan = -1;
    rr_check  = 1'b1;
    out_ready = 1'b1;
    wait_drain();
    rr_check = 1'b0;
    end_test("round-robin fairness");

    apb_access(1'b1, ADDR_DROP, '0, rd, err);
    model_drop = '0;
    mask = NUM_CHAN'($random(seed));
    if (&mask)
      mask[0] = 1'b0;
    apb_access(1'b1, ADDR_CTRL, reg_t'(mask), rd, err);
    model_en = mask;
    for (int i = 0; i < 100; i++)
      send_record(rand_chan(), data_t'($random(seed)));
    wait_drain();
    apb_access(1'b0, ADDR_DROP, '0, rd, err);
    check_reg(rd, model_drop, "DROP count");
    apb_access(1'b1, ADDR_DROP, reg_t'($random(seed)), rd, err);
    model_drop = '0;
    apb_access(1'b0, ADDR_DROP, '0, rd, err);
    check_reg(rd, model_drop, "DROP after clear");
    apb_access(1'b1, ADDR_CTRL, reg_t'({NUM_CHAN{1'b1}}), rd, err);
    model_en = '1;
    end_test("disable and drop");

    out_ready = 1'b0;
    chan_a = rand_chan();
    for (int i = 0; i < DEPTH; i++)
      send_record(chan_a, data_t'($random(seed)));
    send_record(next_chan(chan_a), data_t'($random(seed)));
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_reg(rd, model_status(), "STATUS with channels filled");
    out_ready = 1'b1;
    wait_drain();
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_reg(rd, model_status(), "STATUS after drain");
    apb_access(1'b0, 8'h0C, '0, rd, err);
    check_flag(err, 1'b1, "pslverr on unmapped read");
    end_test("status and errors");

    $display("Tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
